// ==== hsync_gen.sv ====
`timescale 1ns/100ps

module hsync_gen (
	input  logic clk,
	input  logic rst_n,
	input  logic init,         // sampled at cend, restarts the line phase
	input  logic cbeg,
	input  logic pre_cend,
	input  logic cend,
	output logic hblank,
	output logic hsync,
	output logic hpix,         // gate while pixels are shifted out
	output logic line_start,   // one video period before the visible line
	output logic pre_hline,    // same count as line_start but at cbeg
	output logic hsync_start,  // frame timing steps on this one
	output logic hint_start,   // horizontal position of the frame int
	output logic scanin_start  // scan doubler store start
);

	logic [video_timing_pkg::HCNT_W-1:0] hcount; // position in line, steps at cend

	// line counter
	// advances only at cend so it is stable from cbeg to pre_cend
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hcount <= '0;
		else if (cend)
		begin
			if (init || (hcount == (video_timing_pkg::HPERIOD - 9'd1)))
				hcount <= '0; // wrap, or re-phase to the cpu clock
			else
				hcount <= hcount + 9'd1;
		end
	end

	// blank and sync levels
	// set and cleared at cend, one clk after the count reaches the edge
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hblank <= 1'b0;
			hsync  <= 1'b0;
		end
		else if (cend)
		begin
			if (hcount == video_timing_pkg::HBLNK_BEG)
				hblank <= 1'b1;
			else if (hcount == video_timing_pkg::HBLNK_END)
				hblank <= 1'b0;

			if (hcount == video_timing_pkg::HSYNC_BEG)
				hsync <= 1'b1;
			else if (hcount == video_timing_pkg::HSYNC_END)
				hsync <= 1'b0;
		end
	end

	// pixel gate, 256 periods wide
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hpix <= 1'b0;
		else if (cend)
		begin
			if (hcount == video_timing_pkg::HPIX_BEG)
				hpix <= 1'b1;
			else if (hcount == video_timing_pkg::HPIX_END)
				hpix <= 1'b0;
		end
	end

	// one-clk strobes taken at pre_cend, so each one sits on top of cend
	// count is still the old one here, cend moves it on the same edge
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hsync_start  <= 1'b0;
			line_start   <= 1'b0;
			scanin_start <= 1'b0;
			hint_start   <= 1'b0;
		end
		else
		begin
			hsync_start  <= pre_cend && (hcount == video_timing_pkg::HSYNC_BEG);
			line_start   <= pre_cend && (hcount == video_timing_pkg::HBLNK_END); // hblank falls
			scanin_start <= pre_cend && (hcount == video_timing_pkg::SCANIN_BEG);
			hint_start   <= pre_cend && (hcount == video_timing_pkg::HINT_BEG);
		end
	end

	// start strobe for the sprite unit, sampled downstream at post_cbeg
	assign pre_hline = cbeg && (hcount == video_timing_pkg::HBLNK_END);

endmodule

// ==== pixel_coord_gen.sv ====
`timescale 1ns/100ps

module pixel_coord_gen (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                cend,
	input  logic                                hpix,
	input  logic                                vpix,
	input  logic                                line_start,
	input  logic [video_timing_pkg::VCNT_W-1:0] vcount,
	output logic                                pix_valid, // inside 256x192 window
	output logic [video_timing_pkg::PIXX_W-1:0] pixel_x,   // column, 0..255
	output logic [video_timing_pkg::PIXY_W-1:0] pixel_y    // row, 0..191
);

	logic [video_timing_pkg::VCNT_W-1:0] row_diff; // line number relative to first visible row

	// both windows open
	assign pix_valid = hpix && vpix;

	// only the low bits matter inside the visible rows
	assign row_diff = vcount - video_timing_pkg::VPIX_BEG;

	// column counter
	// cleared well before the gate opens, steps once per pixel period
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pixel_x <= '0;
		else if (line_start)
			pixel_x <= '0;
		else if (cend && pix_valid)
			pixel_x <= pixel_x + 8'd1; // wraps to 0 on the last pixel
	end

	// row number, taken at line start when vcount has already stepped
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pixel_y <= '0;
		else if (line_start)
			pixel_y <= row_diff[video_timing_pkg::PIXY_W-1:0];
	end

endmodule

// ==== tb_video_timing.sv ====
`timescale 1ns/100ps

module tb_video_timing;

	localparam int CEND_TIMEOUT = 16;  // clk without cend before the raster counts as stopped
	localparam int LINE_TIMEOUT = 4 * 2 * 448; // clk, two lines

	logic       clk;
	logic       rst_n;
	logic       init;
	logic       cend;
	logic       hblank;
	logic       hsync;
	logic       hpix;
	logic       line_start;
	logic       pre_hline;
	logic       scanin_start;
	logic       vblank;
	logic       vsync;
	logic       int_req;
	logic       pix_valid;
	logic [7:0] pixel_x;
	logic [7:0] pixel_y;

	int   errors;
	int   checks;
	bit   timed_out;
	int   seed;
	int   h;             // horizontal count the DUT holds now
	int   n;             // line steps so far
	int   chk_h;         // cend whose levels are checked one clk later
	int   chk_n;
	bit   chk_pend;
	int   int_left;      // cend periods of int_req still expected
	int   int_rises;
	bit   int_prev;
	int   pix_cnt;       // pixels seen since line_start
	int   clk_cnt;
	int   last_cend_clk;
	bit   cend_seen;
	logic [5:0] exp_lv;

	video_timing_top DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.init         (init),
		.cend         (cend),
		.hblank       (hblank),
		.hsync        (hsync),
		.hpix         (hpix),
		.line_start   (line_start),
		.pre_hline    (pre_hline),
		.scanin_start (scanin_start),
		.vblank       (vblank),
		.vsync        (vsync),
		.int_req      (int_req),
		.pix_valid    (pix_valid),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y)
	);

	always #50 clk = ~clk; // 100 ns period

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got 'h%0h, expected 'h%0h at %0t ns", name, got, exp, $time);
		end
	endtask

	// levels after the cend at horizontal count hidx, lines = line steps before it
	// returns {hblank, hsync, hpix, vblank, vsync, pix_valid}
	function automatic logic [5:0] expected_levels(input int hidx, input int lines);
		int   v;
		logic hb;
		logic hs;
		logic hp;
		logic vb;
		logic vs;
		logic vp;
		hb = (hidx >= video_timing_pkg::HBLNK_BEG) && (hidx < video_timing_pkg::HBLNK_END);
		hs = (hidx >= video_timing_pkg::HSYNC_BEG) && (hidx < video_timing_pkg::HSYNC_END);
		hp = (hidx >= video_timing_pkg::HPIX_BEG) && (hidx < video_timing_pkg::HPIX_END);
		v  = lines % video_timing_pkg::VPERIOD;
		vb = (lines > 0) && (v >= video_timing_pkg::VBLNK_BEG) && (v < video_timing_pkg::VBLNK_END);
		vs = (lines > 0) && (v >= video_timing_pkg::VSYNC_BEG) && (v < video_timing_pkg::VSYNC_END);
		vp = (lines > 0) && (v >= video_timing_pkg::VPIX_BEG) && (v < video_timing_pkg::VPIX_END);
		return {hb, hs, hp, vb, vs, hp && vp}; // no line step yet means reset levels
	endfunction

	// comparing process, runs at negedge where all outputs are settled
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			clk_cnt++;
			if (!cend_seen)
				check_value("outputs before first cend", {hblank, hsync, hpix, line_start,
					pre_hline, scanin_start, vblank, vsync, int_req, pix_valid, pixel_x,
					pixel_y}, 0);
			if (chk_pend)
			begin
				exp_lv = expected_levels(chk_h, chk_n);
				check_value("hblank", hblank, exp_lv[5]);
				check_value("hsync", hsync, exp_lv[4]);
				check_value("hpix", hpix, exp_lv[3]);
				check_value("vblank", vblank, exp_lv[2]);
				check_value("vsync", vsync, exp_lv[1]);
				check_value("pix_valid", pix_valid, exp_lv[0]);
				check_value("pre_hline", pre_hline, h == video_timing_pkg::HBLNK_END); // cbeg clk
				chk_pend = 0;
			end
			if (cend)
			begin
				cend_seen = 1;
				check_value("cend spacing", clk_cnt - last_cend_clk, 4);
				last_cend_clk = clk_cnt;
				check_value("line_start", line_start, h == video_timing_pkg::HBLNK_END);
				check_value("scanin_start", scanin_start, h == video_timing_pkg::SCANIN_BEG);
				check_value("int_req", int_req, int_left > 0);
				if (int_left > 0)
					int_left--;
				if (line_start)
					pix_cnt = 0;
				if (pix_valid)
				begin
					check_value("pixel_x", pixel_x, pix_cnt);
					check_value("pixel_y", pixel_y,
						(n % video_timing_pkg::VPERIOD) - video_timing_pkg::VPIX_BEG);
					pix_cnt++;
				end
				// last line of the frame, int_req from the next cend on
				if ((h == video_timing_pkg::HINT_BEG) &&
					((n % video_timing_pkg::VPERIOD) == video_timing_pkg::VPERIOD - 1))
					int_left = video_timing_pkg::INT_LEN;
				chk_h    = h;
				chk_n    = n;
				chk_pend = 1;
				if (h == video_timing_pkg::HSYNC_BEG)
					n++; // vcount steps on hsync_start
				if (init || (h == video_timing_pkg::HPERIOD - 1))
					h = 0;
				else
					h++;
			end
			if (int_req && !int_prev)
				int_rises++;
			int_prev = int_req;
		end
	end

	task automatic wait_cends(input int count);
		int seen;
		int idle;
		seen = 0;
		idle = 0;
		while ((seen < count) && !timed_out)
		begin
			@(negedge clk);
			idle = cend ? 0 : idle + 1;
			if (cend)
				seen++;
			if (idle > CEND_TIMEOUT)
			begin
				$display("no cend strobe for %0d clk, the raster has stopped", idle);
				timed_out = 1;
			end
		end
	endtask

	// cnt = cend strobes seen, the line_start one included
	task automatic wait_line_start(output int cnt);
		int  spent;
		bit  found;
		cnt   = 0;
		spent = 0;
		found = 0;
		while (!found && !timed_out)
		begin
			@(negedge clk);
			spent++;
			if (cend)
			begin
				cnt++;
				found = line_start;
			end
			if (spent > LINE_TIMEOUT)
			begin
				$display("line_start did not come within two lines");
				timed_out = 1;
			end
		end
	endtask

	// called at the negedge of a cend, puts init on the next cend
	task automatic pulse_init();
		repeat (4) @(posedge clk);
		#1 init = 1'b1;
		@(posedge clk);
		#1 init = 1'b0;
	endtask

	task automatic run_sequence();
		int d;
		int cnt;
		wait_cends(2 * 448);  // two full lines
		if (timed_out)
			return;
		wait_cends(int'(video_timing_pkg::VPERIOD) * int'(video_timing_pkg::HPERIOD));
		if (timed_out)
			return;
		check_value("int_req rises in one frame", int_rises, 1);
		repeat (3)
		begin
			// restart between counts 90 and 139, outside hsync and hpix
			d = 1 + ($unsigned($random(seed)) % 50);
			wait_line_start(cnt);
			if (timed_out)
				return;
			wait_cends(d);
			if (timed_out)
				return;
			pulse_init();
			wait_line_start(cnt);
			if (timed_out)
				return;
			check_value("cends from restart to line_start", cnt - 1, video_timing_pkg::HBLNK_END);
		end
		wait_cends(2 * 448);
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
			checks, errors, DUT.u_props.fail_cnt, timed_out);
		if ((errors == 0) && (DUT.u_props.fail_cnt == 0) && !timed_out)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	initial
	begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		init          = 1'b0;
		seed          = 32'h198e;
		errors        = 0;
		checks        = 0;
		timed_out     = 0;
		h             = 0;
		n             = 0;
		chk_pend      = 0;
		int_left      = 0;
		int_rises     = 0;
		int_prev      = 0;
		pix_cnt       = 0;
		clk_cnt       = 0;
		last_cend_clk = 1; // cbeg on clk 2, so cend on clk 5
		cend_seen     = 0;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		run_sequence();
		finish_run();
	end

endmodule

// ==== video_strobes.sv ====
`timescale 1ns/100ps

module video_strobes (
	input  logic clk,
	input  logic rst_n,
	output logic cbeg,      // first clk of the 7 MHz period
	output logic post_cbeg,
	output logic pre_cend,
	output logic cend       // last clk of the period, the working strobe
);

	// phase that the strobes will show on the next clk
	video_timing_pkg::strobe_phase_e phase;

	// free running phase stepper, 4 clk per 7 MHz period
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			phase <= video_timing_pkg::PH_CBEG; // so cbeg is the first strobe out of reset
		else
			phase <= video_timing_pkg::strobe_phase_e'(phase + 2'd1); // wraps cend -> cbeg
	end

	// strobes are plain flops decoded from the upcoming phase
	// exactly one of them is high on each clk after reset
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cbeg      <= 1'b0;
			post_cbeg <= 1'b0;
			pre_cend  <= 1'b0;
			cend      <= 1'b0;
		end
		else
		begin
			cbeg      <= (phase == video_timing_pkg::PH_CBEG);
			post_cbeg <= (phase == video_timing_pkg::PH_POST_CBEG);
			pre_cend  <= (phase == video_timing_pkg::PH_PRE_CEND);
			cend      <= (phase == video_timing_pkg::PH_CEND);
		end
	end

endmodule

// ==== video_timing_pkg.sv ====
package video_timing_pkg;

	// horizontal timing, counted in 7 MHz pixel periods (one per cend)
	localparam int HCNT_W = 9;                          // horizontal counter width

	localparam logic [HCNT_W-1:0] HPERIOD    = 9'd448; // periods per line
	localparam logic [HCNT_W-1:0] HBLNK_BEG  = 9'd0;   // video ends, blank begins
	localparam logic [HCNT_W-1:0] HBLNK_END  = 9'd88;
	localparam logic [HCNT_W-1:0] HSYNC_BEG  = 9'd10;
	localparam logic [HCNT_W-1:0] HSYNC_END  = 9'd43;  // 33 periods of sync
	localparam logic [HCNT_W-1:0] HPIX_BEG   = 9'd140; // 52 periods after line_start
	localparam logic [HCNT_W-1:0] HPIX_END   = 9'd396; // 256 pixels wide
	localparam logic [HCNT_W-1:0] SCANIN_BEG = 9'd88;  // scan doubler starts storing here
	localparam logic [HCNT_W-1:0] HINT_BEG   = 9'd443; // fine position of the frame int

	// vertical timing, counted in lines
	localparam int VCNT_W = 9;                          // line counter width

	localparam logic [VCNT_W-1:0] VPERIOD   = 9'd320;  // lines per frame
	localparam logic [VCNT_W-1:0] VBLNK_BEG = 9'd0;
	localparam logic [VCNT_W-1:0] VBLNK_END = 9'd32;
	localparam logic [VCNT_W-1:0] VSYNC_BEG = 9'd8;
	localparam logic [VCNT_W-1:0] VSYNC_END = 9'd12;
	localparam logic [VCNT_W-1:0] VPIX_BEG  = 9'd64;
	localparam logic [VCNT_W-1:0] VPIX_END  = 9'd256;  // 192 visible rows

	// frame interrupt
	localparam int INTCNT_W = 6;                        // must hold INT_LEN itself

	localparam logic [INTCNT_W-1:0] INT_LEN = 6'd32;   // int_req length in cend periods

	// pixel coordinates inside the 256x192 window
	localparam int PIXX_W = 8;
	localparam int PIXY_W = 8;

	// four clk phases of one 7 MHz period
	typedef enum logic [1:0]
	{
		PH_CBEG,
		PH_POST_CBEG,
		PH_PRE_CEND,
		PH_CEND
	} strobe_phase_e;

endpackage

// ==== video_timing_properties.sv ====
`timescale 1ns/100ps

module video_timing_properties (
	input logic clk,
	input logic rst_n,
	input logic cbeg,
	input logic pre_cend,
	input logic cend,
	input logic line_start,
	input logic scanin_start,
	input logic int_req
);

	int unsigned int_clks; // clk cycles int_req has been high so far
	int unsigned fail_cnt; // assertion failures so far

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			int_clks <= 0;
		else if (int_req)
			int_clks <= int_clks + 1;
		else
			int_clks <= 0;
	end

	// post_cbeg has no net in the top level, the other three never overlap
	strobes_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({cbeg, pre_cend, cend}))
		else
		begin
			$error("more than one strobe phase active");
			fail_cnt++;
		end

	line_start_on_cend: assert property (@(posedge clk) disable iff (!rst_n)
		line_start |-> cend)
		else
		begin
			$error("line_start off the cend phase");
			fail_cnt++;
		end
	line_start_one_clk: assert property (@(posedge clk) disable iff (!rst_n)
		line_start |=> !line_start)
		else
		begin
			$error("line_start longer than one clk");
			fail_cnt++;
		end

	scanin_on_cend: assert property (@(posedge clk) disable iff (!rst_n)
		scanin_start |-> cend)
		else
		begin
			$error("scanin_start off the cend phase");
			fail_cnt++;
		end
	scanin_one_clk: assert property (@(posedge clk) disable iff (!rst_n)
		scanin_start |=> !scanin_start)
		else
		begin
			$error("scanin_start longer than one clk");
			fail_cnt++;
		end

	// 4 clk per cend period
	int_req_len: assert property (@(posedge clk) disable iff (!rst_n)
		int_clks <= int'(video_timing_pkg::INT_LEN) * 4)
		else
		begin
			$error("int_req held past its length");
			fail_cnt++;
		end

endmodule

bind video_timing_top video_timing_properties u_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.cbeg         (cbeg),
	.pre_cend     (pre_cend),
	.cend         (cend),
	.line_start   (line_start),
	.scanin_start (scanin_start),
	.int_req      (int_req)
);

// ==== video_timing_top.f ====
video_timing_pkg.sv
video_strobes.sv
hsync_gen.sv
vsync_gen.sv
pixel_coord_gen.sv
video_timing_top.sv
video_timing_properties.sv
tb_video_timing.sv

// ==== video_timing_top.sv ====
`timescale 1ns/100ps

module video_timing_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                init,         // re-phase of the line counter
	output logic                                cend,
	output logic                                hblank,
	output logic                                hsync,
	output logic                                hpix,
	output logic                                line_start,
	output logic                                pre_hline,
	output logic                                scanin_start, // to the scan doubler
	output logic                                vblank,
	output logic                                vsync,
	output logic                                int_req,
	output logic                                pix_valid,
	output logic [video_timing_pkg::PIXX_W-1:0] pixel_x,
	output logic [video_timing_pkg::PIXY_W-1:0] pixel_y
);

	logic                                cbeg;
	logic                                pre_cend;
	logic                                hsync_start; // line step for the vertical block
	logic                                hint_start;
	logic                                vpix;
	logic [video_timing_pkg::VCNT_W-1:0] vcount;

	video_strobes u_strobes (
		.clk       (clk),
		.rst_n     (rst_n),
		.cbeg      (cbeg),
		.post_cbeg (),          // no user in the timing core
		.pre_cend  (pre_cend),
		.cend      (cend)
	);

	hsync_gen u_hsync (
		.clk          (clk),
		.rst_n        (rst_n),
		.init         (init),
		.cbeg         (cbeg),
		.pre_cend     (pre_cend),
		.cend         (cend),
		.hblank       (hblank),
		.hsync        (hsync),
		.hpix         (hpix),
		.line_start   (line_start),
		.pre_hline    (pre_hline),
		.hsync_start  (hsync_start),
		.hint_start   (hint_start),
		.scanin_start (scanin_start)
	);

	vsync_gen u_vsync (
		.clk         (clk),
		.rst_n       (rst_n),
		.cend        (cend),
		.hsync_start (hsync_start),
		.hint_start  (hint_start),
		.vblank      (vblank),
		.vsync       (vsync),
		.vpix        (vpix),
		.int_req     (int_req),
		.vcount      (vcount)
	);

	pixel_coord_gen u_pixel (
		.clk        (clk),
		.rst_n      (rst_n),
		.cend       (cend),
		.hpix       (hpix),
		.vpix       (vpix),
		.line_start (line_start),
		.vcount     (vcount),
		.pix_valid  (pix_valid),
		.pixel_x    (pixel_x),
		.pixel_y    (pixel_y)
	);

endmodule

// ==== vsync_gen.sv ====
`timescale 1ns/100ps

module vsync_gen (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                cend,
	input  logic                                hsync_start, // line step
	input  logic                                hint_start,  // int position within a line
	output logic                                vblank,
	output logic                                vsync,
	output logic                                vpix,        // visible rows
	output logic                                int_req,     // frame interrupt to the cpu
	output logic [video_timing_pkg::VCNT_W-1:0] vcount
);

	logic                                  hs_dly;  // hsync_start one clk late, vcount settled
	logic                                  last_line;
	logic [video_timing_pkg::INTCNT_W-1:0] int_cnt; // cend periods left of int_req

	// half-open range check, lo <= v < hi
	function automatic logic in_range(
		input logic [video_timing_pkg::VCNT_W-1:0] v,
		input logic [video_timing_pkg::VCNT_W-1:0] lo,
		input logic [video_timing_pkg::VCNT_W-1:0] hi
	);
		return (v >= lo) && (v < hi);
	endfunction

	assign last_line = (vcount == (video_timing_pkg::VPERIOD - 9'd1));

	// line counter, steps at the start of hsync
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vcount <= '0;
		else if (hsync_start)
		begin
			if (last_line)
				vcount <= '0; // new frame
			else
				vcount <= vcount + 9'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hs_dly <= 1'b0;
		else
			hs_dly <= hsync_start;
	end

	// vertical levels follow the new line number
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vblank <= 1'b0;
			vsync  <= 1'b0;
			vpix   <= 1'b0;
		end
		else if (hs_dly)
		begin
			vblank <= in_range(vcount, video_timing_pkg::VBLNK_BEG, video_timing_pkg::VBLNK_END);
			vsync  <= in_range(vcount, video_timing_pkg::VSYNC_BEG, video_timing_pkg::VSYNC_END);
			vpix   <= in_range(vcount, video_timing_pkg::VPIX_BEG, video_timing_pkg::VPIX_END);
		end
	end

	// frame int: starts at hint_start of the last line, lasts INT_LEN cend periods
	// hint_start comes with a cend, that one is not counted
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			int_req <= 1'b0;
			int_cnt <= '0;
		end
		else if (hint_start && last_line)
		begin
			int_req <= 1'b1;
			int_cnt <= video_timing_pkg::INT_LEN;
		end
		else if (int_req && cend)
		begin
			if (int_cnt == 6'd1)
				int_req <= 1'b0; // last counted period ends here
			int_cnt <= int_cnt - 6'd1;
		end
	end

endmodule
